//--- Makefile
SIM  := obj_dir/Vbackend_tb
SRCS := $(shell grep -v '^+' filelist.f)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) filelist.f
	verilator --binary --timing --assert -f filelist.f --top-module backend_tb --Mdir obj_dir

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -qx "test passed" sim.log
	! grep -qx "test failed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/backend_tb.sv
`timescale 1ns/1ps

module backend_tb import core_pkg::*; ();

    localparam int N_ALU   = 40;
    localparam int N_CHAIN = 20;
    localparam int N_MEM   = 12;
    localparam int N_X0    = 10;
    localparam int N_TOTAL = N_ALU + 1 + N_CHAIN + 4 * N_MEM + N_X0;

    logic            clk;
    logic            rst_n;
    logic            inst_valid_i;
    logic [XLEN-1:0] inst_pc_i;
    logic [31:0]     inst_i;
    logic            inst_ready_o;
    logic            commit_valid_o;
    commit_t         commit;
    wb_m2s_t         wb_m2s;
    wb_s2m_t         wb_s2m;

    logic [XLEN-1:0] xreg [32];
    logic [XLEN-1:0] dmem [logic [XLEN-4:0]];
    commit_t         exp_q [$];
    int              acc_q [$];
    int              cycle;
    int              last_latency;
    int              errors;
    int              mark;
    int              tests_run;
    int              tests_bad;
    string           cur_test;
    logic [XLEN-1:0] next_pc;
    logic            prev_cyc;
    logic            prev_ack;
    wb_m2s_t         prev_req;

    backend_top u_backend_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid_i   (inst_valid_i),
        .inst_pc_i      (inst_pc_i),
        .inst_i         (inst_i),
        .inst_ready_o   (inst_ready_o),
        .wb_o           (wb_m2s),
        .wb_i           (wb_s2m),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit)
    );

    wb_data_mem u_wb_data_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .wb_i  (wb_m2s),
        .wb_o  (wb_s2m)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [63:0] want,
                               input logic [63:0] got);
        assert (want === got) else begin
            $display("ERROR %s: %s expected %h actual %h", cur_test, what, want, got);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic want, input logic got);
        assert (want === got) else begin
            $display("ERROR %s: %s expected %b actual %b", cur_test, what, want, got);
            errors++;
        end
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, F3_D, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [4:0] random_reg();
        return 5'($urandom_range(1, 31));
    endfunction

    function automatic logic [31:0] random_alu(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        logic [11:0] imm;
        imm = 12'($urandom);
        case ($urandom_range(0, 9))
            0: return r_type(F7_BASE, rs2, rs1, F3_ADD, rd);
            1: return r_type(F7_SUB, rs2, rs1, F3_ADD, rd);
            2: return r_type(F7_BASE, rs2, rs1, F3_AND, rd);
            3: return r_type(F7_BASE, rs2, rs1, F3_OR, rd);
            4: return r_type(F7_BASE, rs2, rs1, F3_XOR, rd);
            5: return r_type(F7_BASE, rs2, rs1, F3_SLT, rd);
            6: return i_type(imm, rs1, F3_ADD, rd, OPC_OPIMM);
            7: return i_type({6'd0, imm[5:0]}, rs1, F3_SLL, rd, OPC_OPIMM);
            8: return i_type({6'd0, imm[5:0]}, rs1, F3_SRL, rd, OPC_OPIMM);
            default: return u_type(20'($urandom), rd);
        endcase
    endfunction

    // architectural model, run in issue order at acceptance.
    function automatic commit_t predict(input logic [63:0] pc, input logic [31:0] inst);
        commit_t     c;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm;
        logic [63:0] simm;
        logic [63:0] adr;
        opc  = inst[6:0];
        f3   = inst[14:12];
        f7   = inst[31:25];
        a    = xreg[inst[19:15]];
        b    = xreg[inst[24:20]];
        imm  = {{52{inst[31]}}, inst[31:20]};
        simm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
        c       = '0;
        c.pc    = pc;
        c.inst  = inst;
        c.rd    = inst[11:7];
        c.rd_we = 1'b1;
        if (opc == OPC_OP && f7 == 7'h00 && f3 == 3'b000) c.wdata = a + b;
        else if (opc == OPC_OP && f7 == 7'h20 && f3 == 3'b000) c.wdata = a - b;
        else if (opc == OPC_OP && f7 == 7'h00 && f3 == 3'b111) c.wdata = a & b;
        else if (opc == OPC_OP && f7 == 7'h00 && f3 == 3'b110) c.wdata = a | b;
        else if (opc == OPC_OP && f7 == 7'h00 && f3 == 3'b100) c.wdata = a ^ b;
        else if (opc == OPC_OP && f7 == 7'h00 && f3 == 3'b010)
            c.wdata = {63'd0, $signed(a) < $signed(b)};
        else if (opc == OPC_OPIMM && f3 == 3'b000) c.wdata = a + imm;
        else if (opc == OPC_OPIMM && f3 == 3'b001 && inst[31:26] == 6'd0)
            c.wdata = a << inst[25:20];
        else if (opc == OPC_OPIMM && f3 == 3'b101 && inst[31:26] == 6'd0)
            c.wdata = a >> inst[25:20];
        else if (opc == OPC_LUI) c.wdata = {{32{inst[31]}}, inst[31:12], 12'h000};
        else if (opc == OPC_LOAD && f3 == 3'b011) begin
            adr     = a + imm;
            c.wdata = dmem.exists(adr[63:3]) ? dmem[adr[63:3]] : '0;
        end else begin
            c.rd_we = 1'b0;
            if (opc == OPC_STORE && f3 == 3'b011) begin
                adr              = a + simm;
                dmem[adr[63:3]]  = b;
            end
        end
        if (c.rd_we && c.rd != 5'd0) xreg[c.rd] = c.wdata;
        return c;
    endfunction

    always @(posedge clk) begin
        commit_t want;
        int      acc;
        cycle++;
        if (!rst_n) begin // reset is active high.
            if (commit_valid_o) begin
                assert (exp_q.size() != 0) else begin
                    $display("%s: a commit came out with no instruction pending", cur_test);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    want         = exp_q.pop_front();
                    acc          = acc_q.pop_front();
                    last_latency = cycle - acc;
                    check_value("commit pc", want.pc, commit.pc);
                    check_value("commit inst", 64'(want.inst), 64'(commit.inst));
                    check_bit("commit rd_we", want.rd_we, commit.rd_we);
                    if (want.rd_we) begin
                        check_value("commit rd", 64'(want.rd), 64'(commit.rd));
                        check_value("commit wdata", want.wdata, commit.wdata);
                    end
                end
            end
            if (inst_valid_i && inst_ready_o) begin
                exp_q.push_back(predict(inst_pc_i, inst_i));
                acc_q.push_back(cycle);
            end
            if (prev_cyc && !prev_ack) begin
                check_bit("cyc held until ack", 1'b1, wb_m2s.cyc);
                check_bit("stb held until ack", 1'b1, wb_m2s.stb);
                check_bit("we held until ack", prev_req.we, wb_m2s.we);
                check_value("adr held until ack", prev_req.adr, wb_m2s.adr);
                check_value("dat held until ack", prev_req.dat, wb_m2s.dat);
                check_value("sel held until ack", 64'(prev_req.sel), 64'(wb_m2s.sel));
            end
            if (prev_cyc && prev_ack) check_bit("cyc after ack", 1'b0, wb_m2s.cyc);
            if (wb_m2s.cyc && !wb_s2m.ack) begin
                assert (!inst_ready_o) else begin
                    $display("%s: inst_ready_o was high while an access waited for ack",
                             cur_test);
                    errors++;
                end
            end
            prev_cyc = wb_m2s.cyc;
            prev_ack = wb_s2m.ack;
            prev_req = wb_m2s;
        end
    end

    task automatic issue(input logic [31:0] inst);
        inst_valid_i <= 1'b1;
        inst_pc_i    <= next_pc;
        inst_i       <= inst;
        @(posedge clk);
        while (!inst_ready_o) @(posedge clk);
        next_pc = next_pc + 64'd4;
    endtask

    task automatic drain();
        inst_valid_i <= 1'b0;
        @(posedge clk);
        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        mark     = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == mark) begin
            $display("%s: ok", cur_test);
        end else begin
            tests_bad++;
            $display("%s: %0d failed checks", cur_test, errors - mark);
        end
    endtask

    initial begin
        repeat (N_TOTAL * 20) @(posedge clk);
        $display("watchdog expired after %0d cycles with %0d commits outstanding",
                 cycle, exp_q.size());
        $display("test failed");
        $finish;
    end

    initial begin
        logic [4:0]  rd;
        logic [4:0]  prev;
        logic [4:0]  base;
        logic [4:0]  data;
        logic [4:0]  dest;
        logic [11:0] off;
        void'($urandom(75350));
        rst_n        = 1'b1;
        inst_valid_i = 1'b0;
        inst_pc_i    = '0;
        inst_i       = '0;
        next_pc      = 64'h1000;
        prev_cyc     = 1'b0;
        prev_ack     = 1'b0;
        prev_req     = '0;
        for (int i = 0; i < 32; i++) xreg[i] = '0;

        start_test("reset");
        repeat (4) @(posedge clk);
        check_bit("inst_ready_o in reset", 1'b0, inst_ready_o);
        rst_n <= 1'b0;
        @(posedge clk);
        check_bit("commit_valid_o", 1'b0, commit_valid_o);
        check_bit("cyc", 1'b0, wb_m2s.cyc);
        check_bit("stb", 1'b0, wb_m2s.stb);
        end_test();

        start_test("alu");
        for (int i = 0; i < N_ALU; i++) begin
            issue(random_alu(random_reg(), 5'($urandom), 5'($urandom)));
        end
        drain();
        issue(i_type(12'h123, 5'd3, F3_ADD, 5'd4, OPC_OPIMM)); // isolated.
        drain();
        check_value("isolated commit latency", 64'd3, 64'(last_latency));
        end_test();

        start_test("chain");
        prev = random_reg();
        issue(i_type(12'($urandom), 5'd0, F3_ADD, prev, OPC_OPIMM));
        for (int i = 1; i < N_CHAIN; i++) begin
            rd = random_reg();
            issue(random_alu(rd, prev, $urandom_range(0, 1) != 0 ? prev : random_reg()));
            prev = rd;
        end
        drain();
        end_test();

        start_test("load_store");
        for (int i = 0; i < N_MEM; i++) begin
            base = random_reg();
            data = random_reg();
            dest = random_reg();
            off  = 12'($urandom) & 12'hff8; // doubleword aligned.
            issue(u_type(20'($urandom), base));
            issue(s_type(off, data, base));
            issue(i_type(off, base, F3_D, dest, OPC_LOAD));
            issue(r_type(F7_BASE, dest, dest, F3_ADD, random_reg()));
        end
        drain();
        end_test();

        start_test("x0_illegal");
        issue(i_type(12'h5a5, 5'd0, F3_ADD, 5'd0, OPC_OPIMM));
        issue(u_type(20'habcde, 5'd0));
        issue(r_type(F7_BASE, 5'd0, 5'd0, F3_OR, 5'd9));
        issue(i_type(12'h001, 5'd0, F3_ADD, 5'd10, OPC_OPIMM));
        issue(r_type(7'b0000001, 5'd9, 5'd10, F3_ADD, 5'd11)); // mul.
        issue(i_type(12'h010, 5'd10, F3_SLT, 5'd12, OPC_OPIMM)); // slti.
        issue(i_type(12'h401, 5'd10, F3_SRL, 5'd13, OPC_OPIMM)); // srai.
        issue(i_type(12'h000, 5'd10, 3'b010, 5'd14, OPC_LOAD)); // lw.
        issue({7'h00, 5'd2, 5'd1, 3'b000, 5'd8, 7'b1100011}); // beq.
        issue(r_type(F7_BASE, 5'd11, 5'd12, F3_OR, 5'd15));
        drain();
        end_test();

        $display("tests run %0d, failing tests %0d, failed checks %0d",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- dv/wb_data_mem.sv
`timescale 1ns/1ps

module wb_data_mem import core_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  wb_m2s_t wb_i,
    output wb_s2m_t wb_o
);

    logic [XLEN-1:0] mem [logic [XLEN-4:0]];
    logic            waiting;
    int unsigned     wait_cnt;

    // unwritten words read back a pattern built from every address bit.
    function automatic logic [XLEN-1:0] fill(input logic [XLEN-1:0] adr);
        return {adr[31:0], ~adr[63:32]} ^ 64'h5a5a_c3c3_0f0f_9696;
    endfunction

    always @(posedge clk) begin
        int unsigned     cnt;
        logic [XLEN-4:0] idx;
        logic [XLEN-1:0] word;
        if (rst_n) begin
            wb_o.ack <= 1'b0;
            wb_o.dat <= '0;
            waiting  <= 1'b0;
            wait_cnt <= 0;
        end else begin
            wb_o.ack <= 1'b0;
            if (wb_i.cyc && wb_i.stb && !wb_o.ack) begin
                cnt  = waiting ? wait_cnt : $urandom_range(3, 0); // 0 to 3 wait cycles.
                idx  = wb_i.adr[XLEN-1:3];
                word = mem.exists(idx) ? mem[idx] : fill(wb_i.adr);
                if (cnt == 0) begin
                    if (wb_i.we) begin
                        for (int b = 0; b < 8; b++) begin
                            if (wb_i.sel[b]) word[8*b +: 8] = wb_i.dat[8*b +: 8];
                        end
                        mem[idx] = word;
                    end
                    wb_o.ack <= 1'b1;
                    wb_o.dat <= word;
                    waiting  <= 1'b0;
                end else begin
                    waiting  <= 1'b1;
                    wait_cnt <= cnt - 1;
                end
            end
        end
    end

endmodule

//--- filelist.f
verilog/core_pkg.sv
verilog/regfile.sv
verilog/decode_unit.sv
verilog/alu_exec.sv
verilog/lsu_wb_master.sv
verilog/mem_wb_reg.sv
verilog/backend_top.sv
dv/wb_data_mem.sv
dv/backend_tb.sv

//--- verilog/alu_exec.sv
`timescale 1ns/1ps

module alu_exec import core_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  id_ex_t  id_ex_i,
    input  logic    mem_stall_i,
    output ex_mem_t ex_mem_o
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] alu_res;
    ex_mem_t         ex_mem_q;

    assign op_a   = id_ex_i.op_a;
    assign op_b   = id_ex_i.op_b;
    assign sum    = op_a + op_b; // shared with the ld/sd address.

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:    alu_res = sum;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLL:    alu_res = op_a << op_b[5:0];
            ALU_SRL:    alu_res = op_a >> op_b[5:0];
            ALU_PASS_B: alu_res = op_b; // lui.
            default:    alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            ex_mem_q.valid <= 1'b0;
        end else if (!mem_stall_i) begin
            ex_mem_q.valid      <= id_ex_i.valid;
            ex_mem_q.pc         <= id_ex_i.pc;
            ex_mem_q.inst       <= id_ex_i.inst;
            ex_mem_q.result     <= alu_res;
            ex_mem_q.store_data <= id_ex_i.store_data;
            ex_mem_q.rd         <= id_ex_i.rd;
            ex_mem_q.rd_we      <= id_ex_i.rd_we;
            ex_mem_q.is_load    <= id_ex_i.is_load;
            ex_mem_q.is_store   <= id_ex_i.is_store;
        end
    end

    assign ex_mem_o = ex_mem_q;

endmodule

//--- verilog/backend_top.sv
`timescale 1ns/1ps

module backend_top import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            inst_valid_i,
    input  logic [XLEN-1:0] inst_pc_i,
    input  logic [31:0]     inst_i,
    output logic            inst_ready_o,
    output wb_m2s_t         wb_o,
    input  wb_s2m_t         wb_i,
    output logic            commit_valid_o,
    output commit_t         commit_o
);

    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic              rf_we;
    logic [REG_AW-1:0] rf_waddr;
    logic [XLEN-1:0]   rf_wdata;
    logic              mem_stall;
    id_ex_t            id_ex;
    ex_mem_t           ex_mem;
    mem_wb_t           mem_wb;

    regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .waddr_i    (rf_waddr),
        .wdata_i    (rf_wdata)
    );

    decode_unit u_decode_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid_i (inst_valid_i),
        .inst_pc_i    (inst_pc_i),
        .inst_i       (inst_i),
        .inst_ready_o (inst_ready_o),
        .mem_stall_i  (mem_stall),
        .ex_mem_i     (ex_mem),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .id_ex_o      (id_ex)
    );

    alu_exec u_alu_exec (
        .clk         (clk),
        .rst_n       (rst_n),
        .id_ex_i     (id_ex),
        .mem_stall_i (mem_stall),
        .ex_mem_o    (ex_mem)
    );

    lsu_wb_master u_lsu_wb_master (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_mem_i    (ex_mem),
        .wb_o        (wb_o),
        .wb_i        (wb_i),
        .mem_stall_o (mem_stall),
        .mem_wb_o    (mem_wb)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_wb_i       (mem_wb),
        .mem_stall_i    (mem_stall),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

endmodule

//--- verilog/core_pkg.sv
package core_pkg;

    localparam int XLEN   = 64;
    localparam int REG_AW = 5;

    // major opcodes of the supported subset.
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_D   = 3'b011; // doubleword access.
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [31:0]       inst;
        alu_op_e           alu_op;
        logic [XLEN-1:0]   op_a;
        logic [XLEN-1:0]   op_b;
        logic [XLEN-1:0]   store_data;
        logic [REG_AW-1:0] rd;
        logic              rd_we;
        logic              is_load;
        logic              is_store;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [31:0]       inst;
        logic [XLEN-1:0]   result; // alu result, or address for ld/sd.
        logic [XLEN-1:0]   store_data;
        logic [REG_AW-1:0] rd;
        logic              rd_we;
        logic              is_load;
        logic              is_store;
    } ex_mem_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [31:0]       inst;
        logic [XLEN-1:0]   alu_result;
        logic [XLEN-1:0]   load_data;
        logic [REG_AW-1:0] rd;
        logic              alu_we;
        logic              load_we;
    } mem_wb_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [31:0]       inst;
        logic              rd_we;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   wdata;
    } commit_t;

    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic            we;
        logic [XLEN-1:0] adr;
        logic [XLEN-1:0] dat;
        logic [7:0]      sel;
    } wb_m2s_t;

    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] dat;
    } wb_s2m_t;

endpackage

//--- verilog/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import core_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inst_valid_i,
    input  logic [XLEN-1:0]   inst_pc_i,
    input  logic [31:0]       inst_i,
    output logic              inst_ready_o,
    input  logic              mem_stall_i,
    input  ex_mem_t           ex_mem_i,
    output logic [REG_AW-1:0] rs1_addr_o,
    output logic [REG_AW-1:0] rs2_addr_o,
    input  logic [XLEN-1:0]   rs1_data_i,
    input  logic [XLEN-1:0]   rs2_data_i,
    output id_ex_t            id_ex_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_sh;
    logic            use_rs1;
    logic            use_rs2;
    logic            hit_id_ex;
    logic            hit_ex_mem;
    logic            accept;
    logic            run_q;
    id_ex_t          dec;
    id_ex_t          id_ex_q;

    assign opcode     = inst_i[6:0];
    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign imm_i  = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_s  = {{(XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_u  = {{(XLEN-32){inst_i[31]}}, inst_i[31:12], 12'd0};
    assign imm_sh = {{(XLEN-6){1'b0}}, inst_i[25:20]};

    always_comb begin
        dec            = '0;
        dec.valid      = 1'b1;
        dec.pc         = inst_pc_i;
        dec.inst       = inst_i;
        dec.alu_op     = ALU_ADD;
        dec.op_a       = rs1_data_i;
        dec.op_b       = rs2_data_i;
        dec.store_data = rs2_data_i;
        dec.rd         = inst_i[11:7];
        use_rs1        = 1'b0;
        use_rs2        = 1'b0;
        case (opcode)
            OPC_OP: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                dec.rd_we = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD}: dec.alu_op = ALU_ADD;
                    {F7_SUB, F3_ADD}:  dec.alu_op = ALU_SUB;
                    {F7_BASE, F3_AND}: dec.alu_op = ALU_AND;
                    {F7_BASE, F3_OR}:  dec.alu_op = ALU_OR;
                    {F7_BASE, F3_XOR}: dec.alu_op = ALU_XOR;
                    {F7_BASE, F3_SLT}: dec.alu_op = ALU_SLT;
                    default:           dec.rd_we  = 1'b0; // illegal, commits without write.
                endcase
            end
            OPC_OPIMM: begin
                use_rs1   = 1'b1;
                dec.op_b  = imm_i;
                dec.rd_we = 1'b1;
                if (funct3 == F3_ADD) begin
                    dec.alu_op = ALU_ADD;
                end else if (funct3 == F3_SLL && inst_i[31:26] == 6'd0) begin
                    dec.alu_op = ALU_SLL;
                    dec.op_b   = imm_sh;
                end else if (funct3 == F3_SRL && inst_i[31:26] == 6'd0) begin
                    dec.alu_op = ALU_SRL;
                    dec.op_b   = imm_sh;
                end else begin
                    dec.rd_we = 1'b0;
                end
            end
            OPC_LUI: begin
                dec.alu_op = ALU_PASS_B;
                dec.op_b   = imm_u;
                dec.rd_we  = 1'b1;
            end
            OPC_LOAD: begin
                use_rs1 = 1'b1;
                dec.op_b = imm_i;
                if (funct3 == F3_D) begin
                    dec.is_load = 1'b1;
                    dec.rd_we   = 1'b1;
                end
            end
            OPC_STORE: begin
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                dec.op_b = imm_s;
                dec.is_store = (funct3 == F3_D);
            end
            default: ;
        endcase
    end

    // wait while a source is still owed by an older instruction.
    assign hit_id_ex = id_ex_q.valid && id_ex_q.rd_we &&
                       ((use_rs1 && rs1_addr_o == id_ex_q.rd) ||
                        (use_rs2 && rs2_addr_o == id_ex_q.rd));
    assign hit_ex_mem = ex_mem_i.valid && ex_mem_i.rd_we &&
                        ((use_rs1 && rs1_addr_o == ex_mem_i.rd) ||
                         (use_rs2 && rs2_addr_o == ex_mem_i.rd));

    assign inst_ready_o = run_q && !mem_stall_i && !hit_id_ex && !hit_ex_mem;
    assign accept       = inst_valid_i && inst_ready_o;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            run_q         <= 1'b0;
            id_ex_q.valid <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (!mem_stall_i) begin
                if (accept) id_ex_q <= dec;
                else id_ex_q.valid <= 1'b0; // bubble.
            end
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

//--- verilog/lsu_wb_master.sv
`timescale 1ns/1ps

module lsu_wb_master import core_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  ex_mem_t ex_mem_i,
    output wb_m2s_t wb_o,
    input  wb_s2m_t wb_i,
    output logic    mem_stall_o,
    output mem_wb_t mem_wb_o
);

    logic busy_q;
    logic mem_op;
    logic ack;

    assign mem_op = ex_mem_i.valid && (ex_mem_i.is_load || ex_mem_i.is_store);
    assign ack    = busy_q && wb_i.ack; // ignore a stray ack outside a cycle.

    // one access at a time, cyc drops the cycle after ack.
    always_ff @(posedge clk) begin
        if (rst_n) begin
            busy_q <= 1'b0;
        end else if (ack) begin
            busy_q <= 1'b0;
        end else if (mem_op) begin
            busy_q <= 1'b1;
        end
    end

    // ex_mem is held during the access, so these stay stable until ack.
    always_comb begin
        wb_o.cyc = busy_q;
        wb_o.stb = busy_q;
        wb_o.we  = ex_mem_i.is_store;
        wb_o.adr = ex_mem_i.result;
        wb_o.dat = ex_mem_i.store_data;
        wb_o.sel = 8'hff;
    end

    assign mem_stall_o = mem_op && !ack;

    always_comb begin
        mem_wb_o.valid      = ex_mem_i.valid;
        mem_wb_o.pc         = ex_mem_i.pc;
        mem_wb_o.inst       = ex_mem_i.inst;
        mem_wb_o.alu_result = ex_mem_i.result;
        mem_wb_o.load_data  = wb_i.dat;
        mem_wb_o.rd         = ex_mem_i.rd;
        mem_wb_o.alu_we     = ex_mem_i.rd_we && !ex_mem_i.is_load;
        mem_wb_o.load_we    = ex_mem_i.rd_we && ex_mem_i.is_load;
    end

endmodule

//--- verilog/mem_wb_reg.sv
`timescale 1ns/1ps

module mem_wb_reg import core_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_wb_t           mem_wb_i,
    input  logic              mem_stall_i,
    output logic              rf_we_o,
    output logic [REG_AW-1:0] rf_waddr_o,
    output logic [XLEN-1:0]   rf_wdata_o,
    output logic              commit_valid_o,
    output commit_t           commit_o
);

    mem_wb_t         mem_wb_q;
    logic [XLEN-1:0] wdata;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            mem_wb_q.valid <= 1'b0;
        end else if (mem_stall_i) begin
            mem_wb_q.valid <= 1'b0; // access still open, nothing retires.
        end else begin
            mem_wb_q <= mem_wb_i;
        end
    end

    assign wdata = mem_wb_q.load_we ? mem_wb_q.load_data : mem_wb_q.alu_result;

    assign rf_we_o    = mem_wb_q.valid && (mem_wb_q.alu_we || mem_wb_q.load_we);
    assign rf_waddr_o = mem_wb_q.rd;
    assign rf_wdata_o = wdata;

    assign commit_valid_o = mem_wb_q.valid;

    always_comb begin
        commit_o.pc    = mem_wb_q.pc;
        commit_o.inst  = mem_wb_q.inst;
        commit_o.rd_we = rf_we_o;
        commit_o.rd    = mem_wb_q.rd;
        commit_o.wdata = wdata;
    end

endmodule

//--- verilog/regfile.sv
`timescale 1ns/1ps

module regfile import core_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [REG_AW-1:0] rs1_addr_i,
    input  logic [REG_AW-1:0] rs2_addr_i,
    output logic [XLEN-1:0]   rs1_data_o,
    output logic [XLEN-1:0]   rs2_data_o,
    input  logic              we_i,
    input  logic [REG_AW-1:0] waddr_i,
    input  logic [XLEN-1:0]   wdata_i
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through so decode sees the value retiring this cycle.
    always_comb begin
        if (rs1_addr_i == '0) rs1_data_o = '0;
        else if (we_i && waddr_i == rs1_addr_i) rs1_data_o = wdata_i;
        else rs1_data_o = regs[rs1_addr_i];
    end

    always_comb begin
        if (rs2_addr_i == '0) rs2_data_o = '0;
        else if (we_i && waddr_i == rs2_addr_i) rs2_data_o = wdata_i;
        else rs2_data_o = regs[rs2_addr_i];
    end

endmodule
